// ==== dv/tb_clock_gen.sv ====
// Testbench clock source

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned period_ns = 100  // full clock period
) (
  output logic clk
);

  localparam int unsigned half_ns = period_ns / 2;  // high and low phase

  // free running, starts low so the first edge is a rising one
  initial begin
    clk = 1'b0;
    forever begin
      #(half_ns) clk = ~clk;
    end
  end

endmodule

// ==== dv/tcdm_slice_tb.sv ====
// TCDM slice testbench

`timescale 1ns/1ps

module tcdm_slice_tb import tcdm_pkg::*; ();

  localparam int unsigned depth      = 64;   // bank words
  localparam int unsigned idx_w      = $clog2(depth);
  localparam int unsigned fill_words = 16;   // words loaded with random data
  localparam int unsigned period_ns  = 100;
  localparam int unsigned settle_ns  = period_ns / 10;  // grant settle time
  localparam logic        rd_op      = 1'b1;  // wen high
  localparam logic        wr_op      = 1'b0;  // wen low

  // one table row, stimulus plus the expected grant
  typedef struct packed {
    logic  rd;     // read when high
    addr_t addr;
    data_t data;
    be_t   be;
    user_t user;
    logic  en;     // enable_i
    logic  clr;    // clear_i
    logic  stall;  // stall_i
    logic  gnt;    // expected grant
  } entry_t;

  logic      clk_i;
  logic      rst_ni;
  logic      clear_i;
  logic      enable_i;
  logic      stall_i;
  tcdm_req_t req_i;
  tcdm_rsp_t rsp_o;

  entry_t stim [$];        // stimulus table
  data_t  shadow [depth];  // reference copy of the bank
  user_t  tag_exp;         // reference tag register
  integer seed       = 74;
  int     fail_count = 0;
  logic   stim_ready = 1'b0;  // table built, watchdog may start

  tb_clock_gen #(
    .period_ns (period_ns)
  ) tb_clock_gen_inst (
    .clk (clk_i)
  );

  tcdm_slice_top #(
    .bank_depth (depth)
  ) tcdm_slice_top_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .enable_i (enable_i),
    .stall_i  (stall_i),
    .req_i    (req_i),
    .rsp_o    (rsp_o)
  );

  // compare and stop at the first mismatch
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      fail_count++;
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      $display("Errors found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // build one table row
  function automatic entry_t ent(input logic rd, input addr_t addr, input data_t data,
                                 input be_t be, input user_t user, input logic en,
                                 input logic clr, input logic stall, input logic gnt);
    entry_t e;
    e.rd    = rd;
    e.addr  = addr;
    e.data  = data;
    e.be    = be;
    e.user  = user;
    e.en    = en;
    e.clr   = clr;
    e.stall = stall;
    e.gnt   = gnt;
    return e;
  endfunction

  // write lanes into an old word, one enable per byte
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input be_t be);
    data_t w;
    w = old_word;
    for (int unsigned b = 0; b < be_w; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];  // enabled lane replaced
      end
    end
    return w;
  endfunction

  // random fill followed by the directed rows
  task automatic build_table();
    data_t rnd_data;
    data_t rnd_tag;
    for (int unsigned a = 0; a < fill_words; a++) begin
      rnd_data = $random(seed);
      rnd_tag  = $random(seed);
      stim.push_back(ent(wr_op, addr_t'(a), rnd_data, 4'hf, rnd_tag[3:0],
                         1'b1, 1'b0, 1'b0, 1'b1));
    end
    for (int unsigned a = 0; a < fill_words; a++) begin
      rnd_tag = $random(seed);
      stim.push_back(ent(rd_op, addr_t'(a), 32'h0, 4'h0, rnd_tag[3:0],
                         1'b1, 1'b0, 1'b0, 1'b1));
    end
    // columns: op, addr, data, be, user, en, clr, stall, gnt
    // read after write
    stim.push_back(ent(wr_op, 16'd20, 32'hdeadbeef, 4'hf, 4'h1, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd20, 32'h00000000, 4'h0, 4'h2, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(wr_op, 16'd21, 32'h12345678, 4'hf, 4'h3, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd21, 32'h00000000, 4'h0, 4'h4, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd20, 32'h00000000, 4'h0, 4'h5, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd40, 32'h00000000, 4'h0, 4'h6, 1'b1, 1'b0, 1'b0, 1'b1));
    // byte enable merging
    stim.push_back(ent(wr_op, 16'd22, 32'haabbccdd, 4'hf, 4'h6, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(wr_op, 16'd22, 32'h11223344, 4'h5, 4'h7, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd22, 32'h00000000, 4'h0, 4'h8, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(wr_op, 16'd22, 32'h55667788, 4'h8, 4'h9, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(wr_op, 16'd22, 32'h99999999, 4'h0, 4'ha, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd22, 32'h00000000, 4'h0, 4'hb, 1'b1, 1'b0, 1'b0, 1'b1));
    // stall holds a read, then a write
    stim.push_back(ent(rd_op, 16'd20, 32'h00000000, 4'h0, 4'hc, 1'b1, 1'b0, 1'b1, 1'b0));
    stim.push_back(ent(rd_op, 16'd20, 32'h00000000, 4'h0, 4'hc, 1'b1, 1'b0, 1'b1, 1'b0));
    stim.push_back(ent(rd_op, 16'd20, 32'h00000000, 4'h0, 4'hc, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(wr_op, 16'd23, 32'hcafef00d, 4'hf, 4'hd, 1'b1, 1'b0, 1'b1, 1'b0));
    stim.push_back(ent(wr_op, 16'd23, 32'hcafef00d, 4'hf, 4'hd, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd23, 32'h00000000, 4'h0, 4'he, 1'b1, 1'b0, 1'b0, 1'b1));
    // enable low keeps the last captured tag
    stim.push_back(ent(rd_op, 16'd23, 32'h00000000, 4'h0, 4'h3, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd21, 32'h00000000, 4'h0, 4'h9, 1'b0, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd22, 32'h00000000, 4'h0, 4'hf, 1'b0, 1'b0, 1'b0, 1'b1));
    // clear, also against a same cycle enabled request
    stim.push_back(ent(rd_op, 16'd21, 32'h00000000, 4'h0, 4'h5, 1'b1, 1'b1, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd21, 32'h00000000, 4'h0, 4'h6, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(wr_op, 16'd24, 32'h0badcafe, 4'hf, 4'h7, 1'b0, 1'b1, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd24, 32'h00000000, 4'h0, 4'h8, 1'b1, 1'b0, 1'b0, 1'b1));
    stim.push_back(ent(rd_op, 16'd24, 32'h00000000, 4'h0, 4'h9, 1'b0, 1'b1, 1'b1, 1'b0));
    stim.push_back(ent(rd_op, 16'd24, 32'h00000000, 4'h0, 4'h9, 1'b0, 1'b0, 1'b0, 1'b1));
  endtask

  // drive one row at the falling edge, check the response one edge later
  task automatic apply_entry(input int n, input entry_t e);
    logic  valid_next;
    data_t rdata_next;
    req_i.req  = 1'b1;
    req_i.wen  = e.rd;
    req_i.add  = e.addr;
    req_i.data = e.data;
    req_i.be   = e.be;
    req_i.user = e.user;
    enable_i   = e.en;
    clear_i    = e.clr;
    stall_i    = e.stall;
    #(settle_ns);  // grant is combinational
    check_eq(32'(rsp_o.gnt), 32'(e.gnt), $sformatf("entry %0d gnt", n));
    valid_next = e.gnt & e.rd;                  // only granted reads answer
    rdata_next = shadow[e.addr[idx_w-1:0]];     // word before this edge
    if (e.gnt && !e.rd) begin
      shadow[e.addr[idx_w-1:0]] = merge_bytes(shadow[e.addr[idx_w-1:0]], e.data, e.be);
    end
    if (e.clr) begin
      tag_exp = '0;  // clear beats load
    end else if (e.en) begin
      tag_exp = e.user;  // loads granted or not
    end
    @(negedge clk_i);
    check_eq(32'(rsp_o.r_valid), 32'(valid_next), $sformatf("entry %0d r_valid", n));
    if (valid_next) begin
      check_eq(rsp_o.r_data, rdata_next, $sformatf("entry %0d r_data", n));
    end
    check_eq(32'(rsp_o.r_user), 32'(tag_exp), $sformatf("entry %0d r_user", n));
  endtask

  // main sequence
  initial begin
    rst_ni   = 1'b0;
    clear_i  = 1'b0;
    enable_i = 1'b0;
    stall_i  = 1'b0;
    req_i    = '0;
    tag_exp  = '0;
    for (int unsigned w = 0; w < depth; w++) begin
      shadow[w] = '0;  // bank resets to zero
    end
    build_table();
    stim_ready = 1'b1;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #(settle_ns);
    check_eq(32'(rsp_o.gnt), 32'h0, "gnt after reset");
    check_eq(32'(rsp_o.r_valid), 32'h0, "r_valid after reset");
    check_eq(32'(rsp_o.r_user), 32'h0, "r_user after reset");
    @(negedge clk_i);
    for (int i = 0; i < stim.size(); i++) begin
      apply_entry(i, stim[i]);
    end
    req_i = '0;  // idle bus
    @(negedge clk_i);
    check_eq(32'(rsp_o.r_valid), 32'h0, "r_valid on idle bus");
    if (fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog, four cycles per row plus margin
  initial begin
    int unsigned limit_ns;
    wait (stim_ready);
    limit_ns = (stim.size() + 20) * 4 * period_ns;
    #(limit_ns);
    $display("Timeout: the test did not finish within %0d ns", limit_ns);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== hw/tcdm_pkg.sv ====
// TCDM slice bus types

package tcdm_pkg;

  // bus widths
  localparam int unsigned addr_w = 16;  // word address bits
  localparam int unsigned data_w = 32;  // one data word
  localparam int unsigned be_w   = data_w / 8;  // one enable per byte
  localparam int unsigned user_w = 4;   // initiator tag bits

  // plain vector types with a meaning
  typedef logic [addr_w-1:0] addr_t;  // word address, not byte address
  typedef logic [data_w-1:0] data_t;  // read or write word
  typedef logic [be_w-1:0]   be_t;    // bit n enables byte n
  typedef logic [user_w-1:0] user_t;  // tag echoed on r_user

  // request from initiator toward the bank
  typedef struct packed {
    logic  req;   // request strobe
    logic  wen;   // high for read, low for write
    addr_t add;   // word address
    data_t data;  // write data
    be_t   be;    // byte enables for writes
    user_t user;  // tag, stripped by the filter
  } tcdm_req_t;

  // response back to the initiator
  // gnt is same cycle, the r_ fields follow one cycle later
  typedef struct packed {
    logic  gnt;      // request accepted this cycle
    logic  r_valid;  // read data valid
    data_t r_data;   // read word
    user_t r_user;   // tag of the read being answered
  } tcdm_rsp_t;

  // no ECC and no r_ready at this boundary
  // a response can never be refused

endpackage

// ==== hw/tcdm_r_user_filter.sv ====
// TCDM user tag filter

`timescale 1ns/1ps

module tcdm_r_user_filter import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,   // zero the tag register
  input  logic      enable_i,  // allow tag capture
  input  tcdm_req_t tgt_req,   // from the initiator
  output tcdm_rsp_t tgt_rsp,   // to the initiator
  output tcdm_req_t init_req,  // toward the bank
  input  tcdm_rsp_t init_rsp   // from the bank
);

  user_t user_q;  // tag of the last captured request
  logic  load_tag;  // capture condition

  // capture on every enabled request, granted or not
  // a stalled read keeps its tag held stable so the reload is harmless
  assign load_tag = enable_i & tgt_req.req;

  // request path
  always_comb begin
    init_req      = tgt_req;  // strobe, address, data, be, wen unchanged
    init_req.user = '0;       // tag stays on this side
  end

  // response path
  always_comb begin
    tgt_rsp.gnt     = init_rsp.gnt;      // combinational grant
    tgt_rsp.r_valid = init_rsp.r_valid;  // bank read pulse
    tgt_rsp.r_data  = init_rsp.r_data;   // bank read word
    tgt_rsp.r_user  = user_q;            // shown even when r_valid is low
  end

  // tag register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear_i) begin
      user_q <= '0;  // clear wins over a same cycle load
    end else if (load_tag) begin
      user_q <= tgt_req.user;
    end
  end

  // The registered tag only lines up with r_data when the bank answers a
  // granted read exactly one cycle later. Anywhere else in the cluster the
  // tag would be attached to the wrong response, so both directions of the
  // one cycle rule are checked here against the bank side.

  // granted read then valid next cycle
  property p_read_gnt_then_valid;
    @(posedge clk_i) disable iff (!rst_ni)
      (init_rsp.gnt && init_req.wen) |=> init_rsp.r_valid;
  endproperty

  a_read_gnt_then_valid : assert property (p_read_gnt_then_valid)
    else $error("r_valid missing one cycle after a read grant");

  // no grant then no valid next cycle
  property p_no_gnt_then_no_valid;
    @(posedge clk_i) disable iff (!rst_ni)
      !init_rsp.gnt |=> !init_rsp.r_valid;
  endproperty

  a_no_gnt_then_no_valid : assert property (p_no_gnt_then_no_valid)
    else $error("r_valid high one cycle after a cycle without grant");

endmodule

// ==== hw/tcdm_slice_top.sv ====
// TCDM slice top level

`timescale 1ns/1ps

module tcdm_slice_top import tcdm_pkg::*; #(
  parameter int unsigned bank_depth = 64  // words in the bank
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,   // tag register clear
  input  logic      enable_i,  // tag capture enable
  input  logic      stall_i,   // bank contention
  input  tcdm_req_t req_i,     // from the initiator
  output tcdm_rsp_t rsp_o      // back to the initiator
);

  tcdm_req_t bank_req;  // filter to bank, tag zeroed
  tcdm_rsp_t bank_rsp;  // bank to filter, r_user zero

  // tag filter
  // sits where a read grant is answered one cycle later
  tcdm_r_user_filter tcdm_r_user_filter_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .enable_i (enable_i),
    .tgt_req  (req_i),     // initiator side
    .tgt_rsp  (rsp_o),
    .init_req (bank_req),  // bank side
    .init_rsp (bank_rsp)
  );

  // memory bank
  tcdm_sram_bank #(
    .bank_depth (bank_depth)  // depth set here only
  ) tcdm_sram_bank_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .stall_i (stall_i),   // grant withheld while high
    .req     (bank_req),
    .rsp     (bank_rsp)
  );

endmodule

// ==== hw/tcdm_sram_bank.sv ====
// Single ported TCDM word bank

`timescale 1ns/1ps

module tcdm_sram_bank import tcdm_pkg::*; #(
  parameter int unsigned bank_depth = 64  // number of words
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      stall_i,  // contention stand in, withholds grant
  input  tcdm_req_t req,
  output tcdm_rsp_t rsp
);

  // index width, at least one bit for a single word bank
  localparam int unsigned idx_w = (bank_depth > 1) ? $clog2(bank_depth) : 1;

  typedef logic [idx_w-1:0] idx_t;  // word index into the array

  data_t mem_q [bank_depth];  // storage
  idx_t  idx;                 // low address bits
  logic  gnt;                 // request accepted
  logic  wr_en;               // granted write
  logic  rd_en;               // granted read
  logic  r_valid_q;           // read pulse, one cycle after grant
  data_t r_data_q;            // read word register

  assign idx   = req.add[idx_w-1:0];  // upper address bits ignored
  assign gnt   = req.req & ~stall_i;  // no grant while stalled
  assign wr_en = gnt & ~req.wen;      // wen low means write
  assign rd_en = gnt & req.wen;       // wen high means read

  // word array with byte enable writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned w = 0; w < bank_depth; w++) begin
        mem_q[w] <= '0;  // bank starts all zero
      end
    end else if (wr_en) begin
      for (int unsigned b = 0; b < be_w; b++) begin
        if (req.be[b]) begin
          mem_q[idx][8*b +: 8] <= req.data[8*b +: 8];  // enabled lanes only
        end
      end
    end
  end

  // read valid pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_en;  // writes and stalls give no response
    end
  end

  // read word, loaded only on a granted read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= mem_q[idx];  // sees writes from earlier edges
    end
  end

  // response
  always_comb begin
    rsp.gnt     = gnt;        // same cycle as the request
    rsp.r_valid = r_valid_q;
    rsp.r_data  = r_data_q;   // held between reads
    rsp.r_user  = '0;         // tag comes from the filter
  end

  // the full word address must land inside the bank
  // dropped upper bits would alias onto a lower word
  property p_addr_in_bank;
    @(posedge clk_i) disable iff (!rst_ni)
      req.req |-> (32'(req.add) < bank_depth);
  endproperty

  a_addr_in_bank : assert property (p_addr_in_bank)
    else $error("address %0d outside bank of %0d words", req.add, bank_depth);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TCDM slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir build.log "$log"

# compile with assertions on, timing for the testbench delays
verilator --binary --timing --assert -f verilog.f --top-module tcdm_slice_tb \
  -o tcdm_slice_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tcdm_slice_sim > "$log" 2>&1 \
  || echo "Simulation exited with a non-zero status"

cat "$log"

# the run passes only if the pass line was printed
grep -qx "No errors" "$log" && echo "PASS" && exit 0 \
  || { echo "FAIL, see $log"; exit 1; }

// ==== verilog.f ====
hw/tcdm_pkg.sv
hw/tcdm_r_user_filter.sv
hw/tcdm_sram_bank.sv
hw/tcdm_slice_top.sv
dv/tb_clock_gen.sv
dv/tcdm_slice_tb.sv
